/* files.f */
source/muldiv_arith_pkg.sv
source/muldiv_msg_pkg.sv
source/valrdy_if.sv
source/mul_iterative_dpath.sv
source/mul_iterative_ctrl.sv
source/div_iterative.sv
source/muldiv_dispatch.sv
source/muldiv_top.sv
testbench/muldiv_tb.sv

/* Makefile */
# Verilator flow for the multiply/divide unit
# every variable can be overridden on the command line

VERILATOR   ?= verilator
TOP         ?= muldiv_tb
FILELIST    ?= files.f
BUILD_DIR   ?= obj_dir
LINT_FLAGS  ?= -Wall
SIM_FLAGS   ?= --binary --timing --assert -Wno-fatal
EXTRA_FLAGS ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the model exits non-zero on $fatal, so make fails with it
sim: build
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/muldiv_tb.sv */
`timescale 1ns/1ps
/*
  testbench for the iterative multiply/divide unit
  behavioral reference model, in-order response checks and a watchdog
*/
module muldiv_tb;

  // --------------------------------------------------
  // run length and resp_rdy modes
  // --------------------------------------------------

  localparam int n_mul_rand = 8;
  localparam int n_div_rand = 6;
  localparam int n_directed = 13;
  localparam int n_pairs    = 6;
  // two stall requests at the end
  localparam int total_reqs = n_mul_rand + 2 * n_div_rand + n_directed + 2 * n_pairs + 2;
  localparam int latency    = 33;
  localparam int rdy_high   = 0;
  localparam int rdy_low    = 1;
  localparam int rdy_random = 2;

  logic                              clk = 1'b0;
  logic                              reset;
  logic                              req_val;
  logic                              req_rdy;
  muldiv_arith_pkg::op_t             req_op;
  logic [muldiv_arith_pkg::xlen-1:0] req_a;
  logic [muldiv_arith_pkg::xlen-1:0] req_b;
  logic                              resp_val;
  logic                              resp_rdy = 1'b1;
  logic [muldiv_arith_pkg::rlen-1:0] resp_result;

  int seed       = 77;
  // own stream so the stall pattern does not shift the operands
  int stall_seed = 77;

  // scoreboard with one entry per accepted request
  logic [63:0] exp_q [$];
  string       name_q [$];
  int          acc_q [$];
  bit          iso_q [$];

  string       test_name   = "reset";
  bit          isolated    = 1'b0;
  int          rdy_mode    = rdy_high;
  int          stretch     = 0;
  int          sample_cyc  = 0;
  bit          waiting     = 1'b0;
  logic [63:0] held_result = '0;
  logic [31:0] rnd;

  muldiv_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------
  // reference model and helpers
  // --------------------------------------------------

  // divide result is remainder high, quotient low
  function automatic logic [63:0] expected_result(input muldiv_arith_pkg::op_t op,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    logic signed [63:0] prod;
    logic [31:0]        q;
    logic [31:0]        r;
    prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    // a zero divisor gives all ones over the dividend
    q = '1;
    r = a;
    if (op == muldiv_arith_pkg::op_mul) begin
      return prod;
    end
    if (b != '0) begin
      if (op == muldiv_arith_pkg::op_div && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        q = a;
        r = '0;
      end else if (op == muldiv_arith_pkg::op_div) begin
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
      end else begin
        q = a / b;
        r = a % b;
      end
    end
    return {r, q};
  endfunction

  function automatic logic [31:0] random_operand();
    logic [31:0] v;
    v = $random(seed);
    // now and then a small signed value so quotients vary in size
    if (v[31:30] == 2'b01) begin
      v = {{24{v[7]}}, v[7:0]};
    end
    return v;
  endfunction

  task automatic show_mismatch(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
  endtask

  // --------------------------------------------------
  // resp_rdy driver
  // --------------------------------------------------

  always @(negedge clk) begin
    if (rdy_mode == rdy_high) begin
      resp_rdy = 1'b1;
    end else if (rdy_mode == rdy_low) begin
      resp_rdy = 1'b0;
    end else if (stretch == 0) begin
      // flip and hold for up to 8 cycles
      rnd      = $random(stall_seed);
      resp_rdy = ~resp_rdy;
      stretch  = int'(rnd[2:0]);
    end else begin
      stretch = stretch - 1;
    end
  end

  // --------------------------------------------------
  // monitor
  // --------------------------------------------------

  // sampled mid low phase before the rising edge that acts on the values
  always @(negedge clk) begin
    #5;
    sample_cyc = sample_cyc + 1;
    if (!reset) begin
      // a stalled response must hold val and data
      if (waiting) begin
        assert (resp_val && resp_result == held_result) else begin
          show_mismatch({name_q[0], " held response"}, held_result, resp_result);
          $display("Finished with errors");
          $fatal(1, "response changed while stalled");
        end
      end
      if (resp_val) begin
        assert (exp_q.size() != 0) else begin
          $display("response arrived with no request outstanding");
          $display("Finished with errors");
          $fatal(1, "unexpected response");
        end
        // first cycle of val for an isolated request
        if (!waiting && iso_q[0]) begin
          assert (sample_cyc - acc_q[0] == latency) else begin
            show_mismatch({name_q[0], " latency"}, 64'(latency), 64'(sample_cyc - acc_q[0]));
            $display("Finished with errors");
            $fatal(1, "wrong response latency");
          end
        end
        if (resp_rdy) begin
          assert (resp_result == exp_q[0]) else begin
            show_mismatch(name_q[0], exp_q[0], resp_result);
            $display("Finished with errors");
            $fatal(1, "wrong result");
          end
          void'(exp_q.pop_front());
          void'(name_q.pop_front());
          void'(acc_q.pop_front());
          void'(iso_q.pop_front());
          waiting = 1'b0;
        end else begin
          waiting     = 1'b1;
          held_result = resp_result;
        end
      end
      // record after the response so an empty queue is caught above
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_op, req_a, req_b));
        name_q.push_back(test_name);
        acc_q.push_back(sample_cyc);
        iso_q.push_back(isolated);
      end
    end
  end

  // --------------------------------------------------
  // stimulus tasks
  // --------------------------------------------------

  task automatic drive_req(input muldiv_arith_pkg::op_t op, input logic [31:0] a,
                           input logic [31:0] b);
    @(negedge clk);
    req_val = 1'b1;
    req_op  = op;
    req_a   = a;
    req_b   = b;
  endtask

  // hold the request until the DUT takes it
  task automatic wait_accept();
    #5;
    while (!req_rdy) begin
      @(negedge clk);
      #5;
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic send_req(input muldiv_arith_pkg::op_t op, input logic [31:0] a,
                          input logic [31:0] b);
    drive_req(op, a, b);
    wait_accept();
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic run_isolated(input muldiv_arith_pkg::op_t op, input logic [31:0] a,
                              input logic [31:0] b);
    isolated = 1'b1;
    send_req(op, a, b);
    wait_drain();
  endtask

  // changed on the rising edge, away from the resp_rdy driver
  task automatic set_rdy_mode(input int mode);
    @(posedge clk);
    rdy_mode = mode;
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial begin
    reset   = 1'b1;
    req_val = 1'b0;
    req_op  = muldiv_arith_pkg::op_mul;
    req_a   = '0;
    req_b   = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    #5;
    assert (!resp_val && req_rdy) else begin
      show_mismatch("reset resp_val req_rdy", 64'h1, {62'b0, resp_val, req_rdy});
      $display("Finished with errors");
      $fatal(1, "bad state after reset");
    end

    test_name = "mul_random";
    repeat (n_mul_rand) begin
      run_isolated(muldiv_arith_pkg::op_mul, random_operand(), random_operand());
    end
    test_name = "mul_corner";
    run_isolated(muldiv_arith_pkg::op_mul, 32'h8000_0000, 32'h8000_0000);
    run_isolated(muldiv_arith_pkg::op_mul, 32'hffff_ffff, 32'h0000_0001);
    run_isolated(muldiv_arith_pkg::op_mul, 32'h0000_0000, 32'h1234_5678);
    run_isolated(muldiv_arith_pkg::op_mul, 32'h7fff_ffff, 32'h8000_0000);

    test_name = "div_random";
    repeat (n_div_rand) begin
      run_isolated(muldiv_arith_pkg::op_div, random_operand(), random_operand());
    end
    test_name = "divu_random";
    repeat (n_div_rand) begin
      run_isolated(muldiv_arith_pkg::op_divu, random_operand(), random_operand());
    end

    // -7 and 7 against 2 and -2
    test_name = "div_sign_mix";
    run_isolated(muldiv_arith_pkg::op_div, 32'hffff_fff9, 32'h0000_0002);
    run_isolated(muldiv_arith_pkg::op_div, 32'h0000_0007, 32'hffff_fffe);
    run_isolated(muldiv_arith_pkg::op_div, 32'hffff_fff9, 32'hffff_fffe);
    test_name = "div_overflow";
    run_isolated(muldiv_arith_pkg::op_div, 32'h8000_0000, 32'hffff_ffff);
    test_name = "div_by_zero";
    run_isolated(muldiv_arith_pkg::op_div, 32'h0000_1234, 32'h0000_0000);
    run_isolated(muldiv_arith_pkg::op_div, 32'hffff_fff9, 32'h0000_0000);
    test_name = "divu_corner";
    run_isolated(muldiv_arith_pkg::op_divu, 32'h8000_0000, 32'hffff_ffff);
    run_isolated(muldiv_arith_pkg::op_divu, 32'hffff_ffff, 32'h0000_0000);
    run_isolated(muldiv_arith_pkg::op_divu, 32'h0000_0005, 32'h0000_0007);

    // both units busy with the output stalled at random
    test_name = "mul_div_order";
    isolated  = 1'b0;
    set_rdy_mode(rdy_random);
    repeat (n_pairs) begin
      send_req(muldiv_arith_pkg::op_mul, random_operand(), random_operand());
      send_req(muldiv_arith_pkg::op_div, random_operand(), random_operand());
      wait_drain();
    end

    // second mul waits while the first holds in done
    test_name = "mul_stall";
    set_rdy_mode(rdy_low);
    send_req(muldiv_arith_pkg::op_mul, random_operand(), random_operand());
    drive_req(muldiv_arith_pkg::op_mul, random_operand(), random_operand());
    repeat (latency + 10) begin
      #5;
      assert (!req_rdy) else begin
        show_mismatch("mul_stall req_rdy", 64'h0, {63'b0, req_rdy});
        $display("Finished with errors");
        $fatal(1, "second mul accepted while the first was in flight");
      end
      @(negedge clk);
    end
    set_rdy_mode(rdy_high);
    wait_accept();
    wait_drain();

    $display("Finished with no errors");
    $finish;
  end

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------

  initial begin
    repeat (total_reqs * 40 + 200) @(posedge clk);
    $display("run timed out after %0d cycles", total_reqs * 40 + 200);
    $display("Finished with errors");
    $fatal(1, "timeout");
  end

endmodule

/* source/muldiv_top.sv */
`timescale 1ns/1ps
/*
  multiply/divide unit top level
  dispatch in front of one iterative multiplier and one divider
*/
module muldiv_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req_val,
  output logic                              req_rdy,
  input  muldiv_arith_pkg::op_t             req_op,
  input  logic [muldiv_arith_pkg::xlen-1:0] req_a,
  input  logic [muldiv_arith_pkg::xlen-1:0] req_b,
  output logic                              resp_val,
  input  logic                              resp_rdy,
  output logic [muldiv_arith_pkg::rlen-1:0] resp_result
);

  // --------------------------------------------------
  // unit channels
  // --------------------------------------------------

  valrdy_if #(.msg_t(muldiv_msg_pkg::req_msg_t))  mul_req ();
  valrdy_if #(.msg_t(muldiv_msg_pkg::resp_msg_t)) mul_resp ();
  valrdy_if #(.msg_t(muldiv_msg_pkg::req_msg_t))  div_req ();
  valrdy_if #(.msg_t(muldiv_msg_pkg::resp_msg_t)) div_resp ();

  // multiplier control and status
  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;
  logic result_en;
  logic result_sel;
  logic add_sel;
  logic sign_en;
  logic cnt_sel;
  logic cnt_zero;
  logic b_lsb;

  muldiv_dispatch dispatch_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (req_rdy),
    .resp_rdy    (resp_rdy),
    .resp_val    (resp_val),
    .resp_result (resp_result),
    .mul_req     (mul_req),
    .div_req     (div_req),
    .mul_resp    (mul_resp),
    .div_resp    (div_resp)
  );

  // datapath reads the request payload and drives the response payload
  mul_iterative_dpath mul_dpath_i (
    .clk        (clk),
    .reset      (reset),
    .a          (mul_req.msg.a),
    .b          (mul_req.msg.b),
    .result     (mul_resp.msg.result),
    .a_en       (a_en),
    .a_sel      (a_sel),
    .b_en       (b_en),
    .b_sel      (b_sel),
    .result_en  (result_en),
    .result_sel (result_sel),
    .add_sel    (add_sel),
    .sign_en    (sign_en),
    .cnt_sel    (cnt_sel),
    .cnt_zero   (cnt_zero),
    .b_lsb      (b_lsb),
    .sign       ()
  );

  mul_iterative_ctrl mul_ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .req        (mul_req),
    .resp       (mul_resp),
    .cnt_zero   (cnt_zero),
    .b_lsb      (b_lsb),
    .a_en       (a_en),
    .a_sel      (a_sel),
    .b_en       (b_en),
    .b_sel      (b_sel),
    .result_en  (result_en),
    .result_sel (result_sel),
    .add_sel    (add_sel),
    .sign_en    (sign_en),
    .cnt_sel    (cnt_sel)
  );

  div_iterative div_i (
    .clk   (clk),
    .reset (reset),
    .req   (div_req),
    .resp  (div_resp)
  );

endmodule

/* source/muldiv_dispatch.sv */
`timescale 1ns/1ps
/*
  request steering and in-order response merge
  an order queue of unit tags decides which unit may answer next
*/
module muldiv_dispatch (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req_val,
  input  muldiv_arith_pkg::op_t             req_op,
  input  logic [muldiv_arith_pkg::xlen-1:0] req_a,
  input  logic [muldiv_arith_pkg::xlen-1:0] req_b,
  output logic                              req_rdy,
  input  logic                              resp_rdy,
  output logic                              resp_val,
  output logic [muldiv_arith_pkg::rlen-1:0] resp_result,
  valrdy_if.sender                          mul_req,
  valrdy_if.sender                          div_req,
  valrdy_if.receiver                        mul_resp,
  valrdy_if.receiver                        div_resp
);

  muldiv_msg_pkg::unit_t order_q [muldiv_msg_pkg::order_depth];

  logic [$clog2(muldiv_msg_pkg::order_depth)-1:0]   wr_ptr;
  logic [$clog2(muldiv_msg_pkg::order_depth)-1:0]   rd_ptr;
  logic [$clog2(muldiv_msg_pkg::order_depth+1)-1:0] count;
  muldiv_msg_pkg::unit_t                            target;
  muldiv_msg_pkg::unit_t                            head;
  logic                                             full;
  logic                                             empty;
  logic                                             push;
  logic                                             pop;

  // --------------------------------------------------
  // request side
  // --------------------------------------------------

  assign target = (req_op == muldiv_arith_pkg::op_mul) ? muldiv_msg_pkg::unit_mul
                                                       : muldiv_msg_pkg::unit_div;
  assign full   = (count == muldiv_msg_pkg::order_depth);
  assign empty  = (count == '0);

  // same payload to both, only the target sees val
  assign mul_req.msg = '{op: req_op, a: req_a, b: req_b};
  assign div_req.msg = '{op: req_op, a: req_a, b: req_b};
  assign mul_req.val = req_val && !full && (target == muldiv_msg_pkg::unit_mul);
  assign div_req.val = req_val && !full && (target == muldiv_msg_pkg::unit_div);

  assign req_rdy = !full && ((target == muldiv_msg_pkg::unit_mul) ? mul_req.rdy : div_req.rdy);

  // --------------------------------------------------
  // response side
  // --------------------------------------------------

  assign head = order_q[rd_ptr];

  // the other unit waits in its done state
  assign mul_resp.rdy = resp_rdy && !empty && (head == muldiv_msg_pkg::unit_mul);
  assign div_resp.rdy = resp_rdy && !empty && (head == muldiv_msg_pkg::unit_div);

  assign resp_val    = !empty && ((head == muldiv_msg_pkg::unit_mul) ? mul_resp.val
                                                                     : div_resp.val);
  assign resp_result = (head == muldiv_msg_pkg::unit_mul) ? mul_resp.msg.result
                                                          : div_resp.msg.result;

  assign push = req_val && req_rdy;
  assign pop  = resp_val && resp_rdy;

  // pointers wrap on their own with a power of two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) order_q[wr_ptr] <= target;
  end

endmodule

/* source/div_iterative.sv */
`timescale 1ns/1ps
/*
  iterative restoring divider for div and divu
  quotient in the low half of the result, remainder in the high half
*/
module div_iterative (
  input  logic       clk,
  input  logic       reset,
  valrdy_if.receiver req,
  valrdy_if.sender   resp
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  state_t                             state;
  logic [muldiv_arith_pkg::cnt_w-1:0] cnt;
  // remainder high, quotient low
  logic [muldiv_arith_pkg::rlen-1:0]  rq;
  logic [muldiv_arith_pkg::xlen-1:0]  dvsr;
  logic                               neg_q;
  logic                               neg_r;
  logic                               is_signed;
  logic                               a_neg;
  logic                               b_neg;
  logic [muldiv_arith_pkg::xlen-1:0]  a_mag;
  logic [muldiv_arith_pkg::xlen-1:0]  b_mag;
  logic [muldiv_arith_pkg::xlen:0]    upper;
  logic [muldiv_arith_pkg::xlen:0]    diff;
  logic [muldiv_arith_pkg::rlen-1:0]  rq_step;
  logic [muldiv_arith_pkg::xlen-1:0]  rem;
  logic [muldiv_arith_pkg::xlen-1:0]  quo;

  // --------------------------------------------------
  // operand conditioning
  // --------------------------------------------------

  // divu keeps raw operands
  assign is_signed = (req.msg.op == muldiv_arith_pkg::op_div);
  assign a_neg     = is_signed && req.msg.a[muldiv_arith_pkg::xlen-1];
  assign b_neg     = is_signed && req.msg.b[muldiv_arith_pkg::xlen-1];
  assign a_mag     = a_neg ? (~req.msg.a + 1'b1) : req.msg.a;
  assign b_mag     = b_neg ? (~req.msg.b + 1'b1) : req.msg.b;

  // --------------------------------------------------
  // one restoring step
  // --------------------------------------------------

  // partial remainder after shifting in the next dividend bit
  assign upper = rq[muldiv_arith_pkg::rlen-1:muldiv_arith_pkg::xlen-1];
  assign diff  = upper - {1'b0, dvsr};

  // keep the difference and set the quotient bit when it fits
  // a zero divisor always fits, giving all ones over the dividend
  assign rq_step = (upper >= {1'b0, dvsr})
                 ? {diff[muldiv_arith_pkg::xlen-1:0], rq[muldiv_arith_pkg::xlen-2:0], 1'b1}
                 : {rq[muldiv_arith_pkg::rlen-2:0], 1'b0};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          // all ones is step_count-1
          cnt <= '1;
          if (req.val && req.rdy) state <= st_calc;
        end
        st_calc: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) state <= st_done;
        end
        st_done: if (resp.val && resp.rdy) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && req.val) begin
      rq    <= {{muldiv_arith_pkg::xlen{1'b0}}, a_mag};
      dvsr  <= b_mag;
      // quotient stays all ones on a zero divisor
      neg_q <= (a_neg ^ b_neg) && (req.msg.b != '0);
      // remainder follows the dividend
      neg_r <= a_neg;
    end else if (state == st_calc) begin
      rq <= rq_step;
    end
  end

  // --------------------------------------------------
  // handshake and result
  // --------------------------------------------------

  assign req.rdy  = (state == st_idle);
  assign resp.val = (state == st_done);

  assign rem = rq[muldiv_arith_pkg::rlen-1:muldiv_arith_pkg::xlen];
  assign quo = rq[muldiv_arith_pkg::xlen-1:0];

  assign resp.msg.result = {neg_r ? (~rem + 1'b1) : rem, neg_q ? (~quo + 1'b1) : quo};

endmodule

/* source/mul_iterative_ctrl.sv */
`timescale 1ns/1ps
/*
  multiplier control FSM
  sequences operand load, 32 shift-add steps and the response hold
*/
module mul_iterative_ctrl (
  input  logic       clk,
  input  logic       reset,
  valrdy_if.receiver req,
  valrdy_if.sender   resp,
  input  logic       cnt_zero,
  input  logic       b_lsb,
  output logic       a_en,
  output logic       a_sel,
  output logic       b_en,
  output logic       b_sel,
  output logic       result_en,
  output logic       result_sel,
  output logic       add_sel,
  output logic       sign_en,
  output logic       cnt_sel
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  state_t state;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (req.val && req.rdy) state <= st_calc;
        // last step runs with the counter at zero
        st_calc: if (cnt_zero) state <= st_done;
        st_done: if (resp.val && resp.rdy) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // datapath controls
  // --------------------------------------------------

  always_comb begin
    req.rdy    = 1'b0;
    resp.val   = 1'b0;
    a_en       = 1'b0;
    a_sel      = 1'b0;
    b_en       = 1'b0;
    b_sel      = 1'b0;
    result_en  = 1'b0;
    result_sel = 1'b0;
    add_sel    = 1'b0;
    sign_en    = 1'b0;
    // counter reloads outside of calc
    cnt_sel    = 1'b0;
    case (state)
      st_idle: begin
        req.rdy = 1'b1;
        // load magnitudes, clear accumulator, capture sign
        if (req.val) begin
          a_en      = 1'b1;
          b_en      = 1'b1;
          result_en = 1'b1;
          sign_en   = 1'b1;
        end
      end
      st_calc: begin
        a_en       = 1'b1;
        a_sel      = 1'b1;
        b_en       = 1'b1;
        b_sel      = 1'b1;
        result_en  = 1'b1;
        result_sel = 1'b1;
        add_sel    = b_lsb;
        cnt_sel    = 1'b1;
      end
      st_done: begin
        resp.val = 1'b1;
      end
      default: begin
        resp.val = 1'b0;
      end
    endcase
  end

endmodule

/* source/mul_iterative_dpath.sv */
`timescale 1ns/1ps
/*
  multiplier datapath
  shift-and-add on operand magnitudes, sign applied on the way out
*/
module mul_iterative_dpath (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [muldiv_arith_pkg::xlen-1:0] a,
  input  logic [muldiv_arith_pkg::xlen-1:0] b,
  output logic [muldiv_arith_pkg::rlen-1:0] result,
  input  logic                              a_en,
  input  logic                              a_sel,
  input  logic                              b_en,
  input  logic                              b_sel,
  input  logic                              result_en,
  input  logic                              result_sel,
  input  logic                              add_sel,
  input  logic                              sign_en,
  input  logic                              cnt_sel,
  output logic                              cnt_zero,
  output logic                              b_lsb,
  output logic                              sign
);

  logic [muldiv_arith_pkg::rlen-1:0]  a_reg;
  logic [muldiv_arith_pkg::xlen-1:0]  b_reg;
  logic [muldiv_arith_pkg::rlen-1:0]  acc;
  logic [muldiv_arith_pkg::cnt_w-1:0] cnt;
  logic                               sign_reg;
  logic [muldiv_arith_pkg::xlen-1:0]  a_mag;
  logic [muldiv_arith_pkg::xlen-1:0]  b_mag;
  logic [muldiv_arith_pkg::rlen-1:0]  acc_sum;
  logic [muldiv_arith_pkg::rlen-1:0]  acc_next;

  // --------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------

  assign a_mag = a[muldiv_arith_pkg::xlen-1] ? (~a + 1'b1) : a;
  assign b_mag = b[muldiv_arith_pkg::xlen-1] ? (~b + 1'b1) : b;

  // add the multiplicand when the step bit is set
  assign acc_sum  = acc + a_reg;
  assign acc_next = result_sel ? (add_sel ? acc_sum : acc) : '0;

  // step counter is control state
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (cnt_sel) begin
      cnt <= cnt - 1'b1;
    end else begin
      // all ones is step_count-1
      cnt <= '1;
    end
  end

  always_ff @(posedge clk) begin
    // multiplicand shifts left, multiplier shifts right
    if (a_en) begin
      a_reg <= a_sel ? (a_reg << 1) : {{(muldiv_arith_pkg::rlen - muldiv_arith_pkg::xlen){1'b0}}, a_mag};
    end
    if (b_en) begin
      b_reg <= b_sel ? (b_reg >> 1) : b_mag;
    end
    if (result_en) begin
      acc <= acc_next;
    end
    // product negative when exactly one operand is
    if (sign_en) begin
      sign_reg <= a[muldiv_arith_pkg::xlen-1] ^ b[muldiv_arith_pkg::xlen-1];
    end
  end

  // --------------------------------------------------
  // status and result
  // --------------------------------------------------

  assign cnt_zero = (cnt == '0);
  assign b_lsb    = b_reg[0];
  assign sign     = sign_reg;

  // two's complement applied here so the FSM never tests the sign
  assign result = sign_reg ? (~acc + 1'b1) : acc;

endmodule

/* source/valrdy_if.sv */
`timescale 1ns/1ps
/*
  val/rdy channel with a typed payload
*/
interface valrdy_if #(
  parameter type msg_t = logic
);

  // transfer on a clk edge with val and rdy both high
  logic val;
  logic rdy;
  msg_t msg;

  // producer holds val and msg until the transfer
  modport sender (
    output val,
    output msg,
    input  rdy
  );

  modport receiver (
    input  val,
    input  msg,
    output rdy
  );

endinterface

/* source/muldiv_msg_pkg.sv */
/*
  message formats and unit tags for the multiply/divide unit
*/
package muldiv_msg_pkg;

  // --------------------------------------------------
  // request and response payloads
  // --------------------------------------------------

  // 66 bit request
  typedef struct packed {
    muldiv_arith_pkg::op_t                   op;
    logic [muldiv_arith_pkg::xlen-1:0] a;
    logic [muldiv_arith_pkg::xlen-1:0] b;
  } req_msg_t;

  // 64 bit response
  // divide packs remainder high and quotient low
  typedef struct packed {
    logic [muldiv_arith_pkg::rlen-1:0] result;
  } resp_msg_t;

  // --------------------------------------------------
  // ordering
  // --------------------------------------------------

  // which unit owns an in-flight request
  typedef enum logic {
    unit_mul = 1'b0,
    unit_div = 1'b1
  } unit_t;

  // one slot per unit is enough
  localparam int order_depth = 2;

endpackage

/* source/muldiv_arith_pkg.sv */
/*
  arithmetic definitions for the iterative multiply/divide unit
*/
package muldiv_arith_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // operand width
  localparam int xlen = 32;

  // full product and quotient/remainder pair
  localparam int rlen = 64;

  // --------------------------------------------------
  // iteration
  // --------------------------------------------------

  // one operand bit per step
  localparam int step_count = 32;

  // counter runs step_count-1 down to zero
  localparam int cnt_w = $clog2(step_count);

  // opcodes seen at the request port
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } op_t;

endpackage
